// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= mcu_irq_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
+incdir+.
mcu_irq_pkg.sv
gpio_ao_bank.sv
timer_bank.sv
irq_arbiter.sv
mcu_irq_top.sv
mcu_irq_assert.sv
mcu_irq_tb.sv

// File: gpio_ao_bank.sv
// **************************************************
// pins are async; two-flop sync plus edge register
// only rising edges raise events, gated by irq_en
// **************************************************
`timescale 1ns/10ps
`include "mcu_irq_settings.svh"

module gpio_ao_bank
  import mcu_irq_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      cfg_we_i,
  input  cfg_wr_t                   cfg_i,
  input  logic [`MCU_GPIO_AO_W-1:0] gpio_i,
  output logic [`MCU_GPIO_AO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_AO_W-1:0] gpio_oe_o,
  output logic [`MCU_GPIO_AO_W-1:0] gpio_intr_o
);

  logic                      cfg_hit;
  logic [`MCU_GPIO_AO_W-1:0] out_q;
  logic [`MCU_GPIO_AO_W-1:0] oe_q;
  logic [`MCU_GPIO_AO_W-1:0] irq_en_q;
  logic [`MCU_GPIO_AO_W-1:0] sync1_q;
  logic [`MCU_GPIO_AO_W-1:0] sync2_q;
  logic [`MCU_GPIO_AO_W-1:0] level_q;
  logic [`MCU_GPIO_AO_W-1:0] rise_q;

  assign cfg_hit = cfg_we_i && !cfg_i.sel;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_q    <= '0;
      oe_q     <= '0;
      irq_en_q <= '0;
    end else if (cfg_hit) begin
      out_q    <= cfg_i.word.gpio.out;
      oe_q     <= cfg_i.word.gpio.oe;
      irq_en_q <= cfg_i.word.gpio.irq_en;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      level_q <= '0;
      rise_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      level_q <= sync2_q;
      // low to high on the synchronized level
      rise_q  <= sync2_q & ~level_q;
    end
  end

  assign gpio_o      = out_q;
  assign gpio_oe_o   = oe_q;
  // enable checked late so a disable takes effect at once
  assign gpio_intr_o = rise_q & irq_en_q;

endmodule

// File: irq_arbiter.sv
// **************************************************
// pending bits are sticky until acked by id
// a new event beats an ack on the same source
// **************************************************
`timescale 1ns/10ps
`include "mcu_irq_settings.svh"

module irq_arbiter
  import mcu_irq_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  irq_events_t              events_i,
  input  logic                     irq_ack_i,
  output logic [`MCU_INTR_W-1:0]   irq_o,
  output logic                     irq_valid_o,
  output logic [`MCU_IRQ_ID_W-1:0] irq_id_o
);

  logic [`MCU_FAST_W-1:0]   fast_set;
  logic [`MCU_INTR_W-1:0]   set_vec;
  logic [`MCU_INTR_W-1:0]   clr_vec;
  logic [`MCU_INTR_W-1:0]   pend_d;
  logic [`MCU_INTR_W-1:0]   pend_q;
  logic                     valid_q;
  logic [`MCU_IRQ_ID_W-1:0] id_q;

  // highest index wins
  function automatic logic [`MCU_IRQ_ID_W-1:0] top_bit(logic [`MCU_INTR_W-1:0] vec);
    logic [`MCU_IRQ_ID_W-1:0] id;
    id = '0;
    for (int i = 0; i < `MCU_INTR_W; i++) begin
      if (vec[i]) begin
        id = i[`MCU_IRQ_ID_W-1:0];
      end
    end
    return id;
  endfunction

  always_comb begin
    // fast vector holds timers 1..3 then gpio pins with the top bits unused
    fast_set = '0;
    fast_set[`MCU_TIMER_NUM-2:0] = events_i.timer[`MCU_TIMER_NUM-1:1];
    fast_set[`MCU_TIMER_NUM-1 +: `MCU_GPIO_AO_W] = events_i.gpio;

    set_vec = '0;
    set_vec[`MCU_MTIMER_BIT] = events_i.timer[0];
    set_vec[`MCU_FAST_BASE +: `MCU_FAST_W] = fast_set;
  end

  always_comb begin
    clr_vec = '0;
    if (irq_ack_i && valid_q) begin
      clr_vec[id_q] = 1'b1;
    end
  end

  assign pend_d = (pend_q & ~clr_vec) | set_vec;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pend_q  <= '0;
      valid_q <= 1'b0;
      id_q    <= '0;
    end else begin
      pend_q  <= pend_d;
      valid_q <= |pend_d;
      id_q    <= top_bit(pend_d);
    end
  end

  assign irq_o       = pend_q;
  assign irq_valid_o = valid_q;
  assign irq_id_o    = id_q;

endmodule

// File: mcu_irq_assert.sv
// **************************************************
// bound twice, to the arbiter and to the gpio bank
// unused inputs are tied off in each bind
// **************************************************
`timescale 1ns/10ps
`include "mcu_irq_settings.svh"

module mcu_irq_assert
  import mcu_irq_pkg::*;
(
  input logic                             clk_i,
  input logic                             arst_n_i,
  input logic [`MCU_INTR_W-1:0]           irq_i,
  input logic                             irq_valid_i,
  input logic [`MCU_IRQ_ID_W-1:0]         irq_id_i,
  input logic [$bits(irq_events_t)-1:0]   events_i,
  input logic [$bits(irq_events_t)-1:0]   events_en_i
);

  logic valid_bad = 1'b0;
  logic id_bad    = 1'b0;
  logic en_bad    = 1'b0;
  logic pulse_bad = 1'b0;
  logic fail_seen;

  assign fail_seen = valid_bad | id_bad | en_bad | pulse_bad;

  valid_matches_vec: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_valid_i == (irq_i != '0))
    else begin
      $error("irq_valid_o disagrees with irq_o");
      valid_bad = 1'b1;
    end

  id_bit_set: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    irq_valid_i |-> irq_i[irq_id_i])
    else begin
      $error("irq_id_o names a bit that is clear in irq_o");
      id_bad = 1'b1;
    end

  // disabled gpio pins never raise an event
  event_enabled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (events_i & ~events_en_i) == '0)
    else begin
      $error("event on a source whose interrupt is disabled");
      en_bad = 1'b1;
    end

  event_one_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (events_i & $past(events_i)) == '0)
    else begin
      $error("event pulse held for more than one cycle");
      pulse_bad = 1'b1;
    end

endmodule

bind irq_arbiter mcu_irq_assert arbiter_chk (
  .clk_i,
  .arst_n_i,
  .irq_i(irq_o),
  .irq_valid_i(irq_valid_o),
  .irq_id_i(irq_id_o),
  .events_i(events_i),
  .events_en_i('1)
);

bind gpio_ao_bank mcu_irq_assert gpio_chk (
  .clk_i,
  .arst_n_i,
  .irq_i('0),
  .irq_valid_i(1'b0),
  .irq_id_i('0),
  .events_i({gpio_intr_o, {`MCU_TIMER_NUM{1'b0}}}),
  .events_en_i({irq_en_q, {`MCU_TIMER_NUM{1'b1}}})
);

// File: mcu_irq_pkg.sv
// **************************************************
// config word is one 32-bit value, decoded per bank
// **************************************************
`include "mcu_irq_settings.svh"

package mcu_irq_pkg;

  localparam int CFG_W = 32;

  typedef struct packed {
    logic [CFG_W-3*`MCU_GPIO_AO_W-1:0] rsvd;
    logic [`MCU_GPIO_AO_W-1:0]         irq_en;
    logic [`MCU_GPIO_AO_W-1:0]         oe;
    logic [`MCU_GPIO_AO_W-1:0]         out;
  } gpio_cfg_t;

  typedef struct packed {
    logic [CFG_W-`MCU_TIMER_W-2:0] rsvd;
    logic                          enable;
    logic [`MCU_TIMER_W-1:0]       compare;
  } timer_cfg_t;

  // one written word read as gpio or timer setup
  typedef union packed {
    gpio_cfg_t  gpio;
    timer_cfg_t timer;
  } cfg_word_u;

  typedef struct packed {
    logic                               sel;
    logic [$clog2(`MCU_TIMER_NUM)-1:0] idx;
    cfg_word_u                          word;
  } cfg_wr_t;

  typedef struct packed {
    logic [`MCU_GPIO_AO_W-1:0] gpio;
    logic [`MCU_TIMER_NUM-1:0] timer;
  } irq_events_t;

endpackage

// File: mcu_irq_settings.svh
// **************************************************
// widths and counts for the interrupt slice
// vector bit positions follow the core's irq layout
// **************************************************
`ifndef MCU_IRQ_SETTINGS_SVH
`define MCU_IRQ_SETTINGS_SVH

// always-on gpio pins and compare timers
`define MCU_GPIO_AO_W 8
`define MCU_TIMER_NUM 4
`define MCU_TIMER_W 16

// core interrupt vector layout
`define MCU_INTR_W 32
`define MCU_FAST_W 15
`define MCU_FAST_BASE 16
`define MCU_MTIMER_BIT 7
`define MCU_IRQ_ID_W 5

`endif

// File: mcu_irq_stimulus.txt
// op_test_arg_aux_data; op 01 write (arg bit4 sel, bits1:0 idx), 02 pins, 03 ack, 04 wait data
// 05 check irq (arg id, aux valid, data vector), 06 check gpio (data oe[15:8] out[7:0]), ff end
05_00_00_00_00000000
06_00_00_00_00000000
01_01_00_00_00053ca5
06_01_00_00_00003ca5
02_02_00_00_00000004
04_02_00_00_00000002
05_02_00_00_00000000
05_02_15_01_00200000
03_02_00_00_00000000
05_02_00_00_00000000
02_03_00_00_0000000c
04_03_00_00_00000004
05_03_00_00_00000000
02_03_00_00_00000000
04_03_00_00_00000003
01_04_10_00_00010009
04_04_00_00_0000000a
05_04_00_00_00000000
05_04_07_01_00000080
01_04_10_00_00000009
01_05_12_00_00010003
04_05_00_00_00000004
05_05_07_01_00000080
05_05_11_01_00020080
01_05_12_00_00000003
03_05_00_00_00000000
05_05_07_01_00000080
02_06_00_00_00000001
04_06_00_00_00000003
05_06_13_01_00080080
03_06_00_00_00000000
05_06_07_01_00000080
03_06_00_00_00000000
05_06_00_00_00000000
ff_00_00_00_00000000

// File: mcu_irq_tb.sv
// **************************************************
// replays the stimulus file, one command per cycle
// checks sample at the falling edge after the command
// **************************************************
`timescale 1ns/10ps
`include "mcu_irq_settings.svh"

module mcu_irq_tb
  import mcu_irq_pkg::*;
();

  localparam int         DEPTH    = 64;
  localparam logic [7:0] OP_WRITE = 8'h01;
  localparam logic [7:0] OP_PINS  = 8'h02;
  localparam logic [7:0] OP_ACK   = 8'h03;
  localparam logic [7:0] OP_WAIT  = 8'h04;
  localparam logic [7:0] OP_IRQ   = 8'h05;
  localparam logic [7:0] OP_GPIO  = 8'h06;
  localparam logic [7:0] OP_END   = 8'hff;

  logic                      clk = 1'b0;
  logic                      arst_n;
  logic                      cfg_we;
  cfg_wr_t                   cfg;
  logic [`MCU_GPIO_AO_W-1:0] gpio_in;
  logic [`MCU_GPIO_AO_W-1:0] gpio_out;
  logic [`MCU_GPIO_AO_W-1:0] gpio_oe;
  logic                      irq_ack;
  logic [`MCU_INTR_W-1:0]    irq;
  logic                      irq_valid;
  logic [`MCU_IRQ_ID_W-1:0]  irq_id;

  logic [63:0] cmds [DEPTH];
  int          errors;
  int          cycles = 0;
  int          cycle_limit;

  mcu_irq_top dut (
    .clk_i(clk),
    .arst_n_i(arst_n),
    .cfg_we_i(cfg_we),
    .cfg_i(cfg),
    .gpio_i(gpio_in),
    .gpio_o(gpio_out),
    .gpio_oe_o(gpio_oe),
    .irq_ack_i(irq_ack),
    .irq_o(irq),
    .irq_valid_o(irq_valid),
    .irq_id_o(irq_id)
  );

  always #5 clk = ~clk;

  // watchdog limit is set once the file is loaded
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout: the run did not end within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  function automatic string test_name(logic [7:0] id);
    case (id)
      8'h00:   return "reset";
      8'h01:   return "gpio_cfg";
      8'h02:   return "gpio_irq";
      8'h03:   return "gpio_noirq";
      8'h04:   return "timer0";
      8'h05:   return "timer2";
      8'h06:   return "priority";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_irq(logic [7:0] test, logic [4:0] exp_id, logic exp_valid,
                           logic [31:0] exp_vec);
    @(negedge clk);
    if (irq !== exp_vec) begin
      $display("CHECK FAILED %s irq: expected %h actual %h", test_name(test), exp_vec, irq);
      errors++;
    end
    if (irq_valid !== exp_valid) begin
      $display("CHECK FAILED %s valid: expected %b actual %b", test_name(test), exp_valid,
               irq_valid);
      errors++;
    end
    // id only has a meaning while valid
    if (exp_valid && irq_id !== exp_id) begin
      $display("CHECK FAILED %s id: expected %0d actual %0d", test_name(test), exp_id, irq_id);
      errors++;
    end
  endtask

  task automatic check_gpio(logic [7:0] test, logic [7:0] exp_oe, logic [7:0] exp_out);
    @(negedge clk);
    if (gpio_out !== exp_out) begin
      $display("CHECK FAILED %s gpio_o: expected %h actual %h", test_name(test), exp_out,
               gpio_out);
      errors++;
    end
    if (gpio_oe !== exp_oe) begin
      $display("CHECK FAILED %s gpio_oe_o: expected %h actual %h", test_name(test), exp_oe,
               gpio_oe);
      errors++;
    end
  endtask

  task automatic run_cmd(logic [63:0] c);
    logic [7:0]  op;
    logic [7:0]  test;
    logic [7:0]  arg;
    logic [7:0]  aux;
    logic [31:0] data;
    op   = c[63:56];
    test = c[55:48];
    arg  = c[47:40];
    aux  = c[39:32];
    data = c[31:0];
    @(posedge clk);
    cfg_we  <= 1'b0;
    irq_ack <= 1'b0;
    case (op)
      OP_WRITE: begin
        cfg_we   <= 1'b1;
        cfg.sel  <= arg[4];
        cfg.idx  <= arg[1:0];
        cfg.word <= data;
      end
      OP_PINS: gpio_in <= data[7:0];
      OP_ACK:  irq_ack <= 1'b1;
      OP_WAIT: repeat (data - 1) @(posedge clk);
      OP_IRQ:  check_irq(test, arg[4:0], aux[0], data);
      OP_GPIO: check_gpio(test, data[15:8], data[7:0]);
      default: begin
        $display("unknown command %h in the stimulus file", op);
        errors++;
      end
    endcase
  endtask

  initial begin
    int idx;
    int asrt_errors;
    arst_n  <= 1'b0;
    cfg_we  <= 1'b0;
    cfg     <= '0;
    gpio_in <= '0;
    irq_ack <= 1'b0;
    errors      = 0;
    cycle_limit = 0;
    for (int i = 0; i < DEPTH; i++) begin
      cmds[i] = {OP_END, 56'h0};
    end
    $readmemh("mcu_irq_stimulus.txt", cmds);
    for (int i = 0; i < DEPTH; i++) begin
      if (cmds[i][63:56] == OP_WAIT) begin
        cycle_limit += cmds[i][31:0];
      end
    end
    cycle_limit += 200;

    repeat (16) @(posedge clk);
    arst_n <= 1'b1;
    idx = 0;
    while (idx < DEPTH && cmds[idx][63:56] != OP_END) begin
      run_cmd(cmds[idx]);
      idx++;
    end

    asrt_errors = int'(dut.irq_arbiter_i.arbiter_chk.fail_seen) +
                  int'(dut.gpio_ao_bank_i.gpio_chk.fail_seen);
    $display("errors: %0d check, %0d assertion", errors, asrt_errors);
    if (errors == 0 && asrt_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: mcu_irq_top.sv
// **************************************************
// gpio pin rise reaches irq_o after 4 cycles
// timer match pulse reaches irq_o after 1 cycle
// **************************************************
`timescale 1ns/10ps
`include "mcu_irq_settings.svh"

module mcu_irq_top
  import mcu_irq_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      cfg_we_i,
  input  cfg_wr_t                   cfg_i,
  input  logic [`MCU_GPIO_AO_W-1:0] gpio_i,
  output logic [`MCU_GPIO_AO_W-1:0] gpio_o,
  output logic [`MCU_GPIO_AO_W-1:0] gpio_oe_o,
  input  logic                      irq_ack_i,
  output logic [`MCU_INTR_W-1:0]    irq_o,
  output logic                      irq_valid_o,
  output logic [`MCU_IRQ_ID_W-1:0]  irq_id_o
);

  irq_events_t events;

  gpio_ao_bank gpio_ao_bank_i (
    .clk_i,
    .arst_n_i,
    .cfg_we_i,
    .cfg_i,
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .gpio_intr_o(events.gpio)
  );

  timer_bank timer_bank_i (
    .clk_i,
    .arst_n_i,
    .cfg_we_i,
    .cfg_i,
    .timer_intr_o(events.timer)
  );

  irq_arbiter irq_arbiter_i (
    .clk_i,
    .arst_n_i,
    .events_i(events),
    .irq_ack_i,
    .irq_o,
    .irq_valid_o,
    .irq_id_o
  );

endmodule

// File: timer_bank.sv
// **************************************************
// period is compare+1 cycles; compare 0 fires always
// a write restarts the addressed counter from zero
// **************************************************
`timescale 1ns/10ps
`include "mcu_irq_settings.svh"

module timer_bank
  import mcu_irq_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      cfg_we_i,
  input  cfg_wr_t                   cfg_i,
  output logic [`MCU_TIMER_NUM-1:0] timer_intr_o
);

  localparam int IDX_W = $clog2(`MCU_TIMER_NUM);

  logic [`MCU_TIMER_W-1:0]   cnt_q [`MCU_TIMER_NUM];
  logic [`MCU_TIMER_W-1:0]   cmp_q [`MCU_TIMER_NUM];
  logic [`MCU_TIMER_NUM-1:0] en_q;
  logic [`MCU_TIMER_NUM-1:0] intr_q;
  logic [`MCU_TIMER_NUM-1:0] wr_hit;
  logic [`MCU_TIMER_NUM-1:0] match;

  always_comb begin
    for (int i = 0; i < `MCU_TIMER_NUM; i++) begin
      wr_hit[i] = cfg_we_i && cfg_i.sel && (cfg_i.idx == i[IDX_W-1:0]);
      match[i]  = en_q[i] && (cnt_q[i] == cmp_q[i]);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `MCU_TIMER_NUM; i++) begin
      if (wr_hit[i]) begin
        cmp_q[i] <= cfg_i.word.timer.compare;
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      en_q   <= '0;
      intr_q <= '0;
      for (int i = 0; i < `MCU_TIMER_NUM; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      intr_q <= match;
      for (int i = 0; i < `MCU_TIMER_NUM; i++) begin
        if (wr_hit[i]) begin
          en_q[i]  <= cfg_i.word.timer.enable;
          cnt_q[i] <= '0;
        end else if (match[i]) begin
          cnt_q[i] <= '0;
        end else if (en_q[i]) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  assign timer_intr_o = intr_q;

endmodule
